// File: design/sdram_config.svh
/* widths and timing of the sdram request front end
   include in any file that sizes a bus or counts cycles */
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// word address per bank, row above column
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 9
`define SDRAM_AW    22

// one 16-bit word per access
`define SDRAM_DW    16

// cycles, counted at the controller clock
`define SDRAM_TRCD  2
`define SDRAM_CL    2
// busy time after the auto-precharging command, write recovery included
`define SDRAM_TRP   3

// 1 registers the client requests, 0 passes them straight through
`define SDRAM_LATCH 1

`endif

// File: design/sdram_pkg.sv
/* shared types for the sdram front end
   command pin patterns and the per-bank word address */
`include "sdram_config.svh"

package sdram_pkg;

    // pin pattern {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        // chip selected, no operation
        CMD_NOP   = 4'b0111,
        // open a row
        CMD_ACT   = 4'b0011,
        // column read, a[10] picks auto-precharge
        CMD_READ  = 4'b0101,
        // column write, same a[10] rule
        CMD_WRITE = 4'b0100
    } sdram_cmd_e;

    // word address as the client gives it
    typedef struct packed {
        // upper bits select the row
        logic [`SDRAM_ROW_W-1:0] row;
        // lower bits select the column
        logic [`SDRAM_COL_W-1:0] col;
    } sdram_addr_t;

    // number of banks, one client each
    localparam int NUM_BANKS = 4;

    // bank index width on the pins
    localparam int BA_W = 2;

endpackage

// File: design/sdram_bank_if.sv
/* command slot between one bank sequencer and the command arbiter
   the sequencer holds its request until grant, read data comes back here */
`timescale 1ns/1ps
`include "sdram_config.svh"

interface sdram_bank_if import sdram_pkg::*; ();

    // request side, held stable until grant
    logic                    req;
    sdram_cmd_e              cmd;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_COL_W-1:0] col;
    logic [`SDRAM_DW-1:0]    wdata;

    // high in the cycle the command is on the pins
    logic                    grant;

    // one pulse, CL cycles after the read grant
    logic                    rvalid;
    logic [`SDRAM_DW-1:0]    rdata;

    modport seq (
        output req, cmd, row, col, wdata,
        input  grant, rvalid, rdata
    );

    modport arb (
        input  req, cmd, row, col, wdata,
        output grant, rvalid, rdata
    );

endinterface

// File: design/sdram_req_latch.sv
/* optional register stage in front of the four bank sequencers
   SDRAM_LATCH picks a one-cycle register or a plain pass-through */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_req_latch import sdram_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_addr_t          addr    [4],
    input  logic [`SDRAM_DW-1:0] wdata   [4],
    input  logic [3:0]           rd,
    input  logic [3:0]           wr,
    output sdram_addr_t          addr_l  [4],
    output logic [`SDRAM_DW-1:0] wdata_l [4],
    output logic [3:0]           rd_l,
    output logic [3:0]           wr_l
);

    generate
        if (`SDRAM_LATCH == 1) begin : g_reg
            // cuts the client path, costs one cycle
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int i = 0; i < 4; i++) begin
                        addr_l[i]  <= '0;
                        wdata_l[i] <= '0;
                    end
                    rd_l <= '0;
                    wr_l <= '0;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        addr_l[i]  <= addr[i];
                        wdata_l[i] <= wdata[i];
                    end
                    rd_l <= rd;
                    wr_l <= wr;
                end
            end
        end else begin : g_comb
            // no added latency
            always_comb begin
                for (int i = 0; i < 4; i++) begin
                    addr_l[i]  = addr[i];
                    wdata_l[i] = wdata[i];
                end
                rd_l = rd;
                wr_l = wr;
            end
        end
    endgenerate

endmodule

// File: design/sdram_bank_seq.sv
/* per-bank sequencer, one access at a time with auto-precharge
   asks the arbiter for an ACT slot, then a READ or WRITE slot */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_bank_seq import sdram_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_addr_t          addr,
    input  logic [`SDRAM_DW-1:0] wdata,
    input  logic                 rd,
    input  logic                 wr,
    output logic [`SDRAM_DW-1:0] rdata,
    output logic                 ack,
    sdram_bank_if.seq            bus
);

    // one counter serves both the rcd and the precharge wait
    localparam int CNT_MAX = (`SDRAM_TRP > `SDRAM_TRCD) ? `SDRAM_TRP : `SDRAM_TRCD;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_ACT      = 3'd1;
    localparam logic [2:0] ST_RCD      = 3'd2;
    localparam logic [2:0] ST_ACCESS   = 3'd3;
    localparam logic [2:0] ST_RD_WAIT  = 3'd4;
    localparam logic [2:0] ST_PRE_WAIT = 3'd5;

    logic [2:0]       state;
    logic [CNT_W-1:0] cnt;
    // operation taken when the request was accepted
    logic             op_wr;

    // request to the arbiter
    // idle asks at once so ACT reaches the pins one cycle after the request
    always_comb begin
        case (state)
            ST_IDLE:           bus.req = rd | wr;
            ST_ACT, ST_ACCESS: bus.req = 1'b1;
            // ask one cycle early, the column command lands TRCD after ACT
            ST_RCD:            bus.req = (cnt == '0);
            default:           bus.req = 1'b0;
        endcase
    end

    assign bus.cmd   = (state == ST_IDLE || state == ST_ACT) ? CMD_ACT :
                       op_wr ? CMD_WRITE : CMD_READ;
    // client holds address and data until ack
    assign bus.row   = addr.row;
    assign bus.col   = addr.col;
    assign bus.wdata = wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
            op_wr <= 1'b0;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rd | wr) begin
                        op_wr <= wr;
                        state <= ST_ACT;
                    end
                end
                // grant here means ACT is on the pins this cycle
                ST_ACT: begin
                    if (bus.grant) begin
                        cnt   <= CNT_W'(`SDRAM_TRCD - 2);
                        state <= ST_RCD;
                    end
                end
                ST_RCD: begin
                    if (cnt == '0) begin
                        state <= ST_ACCESS;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // waits here while other banks win the bus
                ST_ACCESS: begin
                    if (bus.grant) begin
                        cnt <= CNT_W'(`SDRAM_TRP - 1);
                        if (op_wr) begin
                            // write done once it is on the pins
                            ack   <= 1'b1;
                            state <= ST_PRE_WAIT;
                        end else begin
                            state <= ST_RD_WAIT;
                        end
                    end
                end
                // precharge time keeps running during the CAS latency
                ST_RD_WAIT: begin
                    if (bus.rvalid) begin
                        ack   <= 1'b1;
                        state <= ST_PRE_WAIT;
                        // stay busy until the dropped request has passed the latch
                        cnt   <= (cnt > CNT_W'(`SDRAM_LATCH)) ? cnt - 1'b1 :
                                 CNT_W'(`SDRAM_LATCH);
                    end else if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_PRE_WAIT: begin
                    if (cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read word held for the ack cycle
    always_ff @(posedge clk) begin
        if (state == ST_RD_WAIT && bus.rvalid) begin
            rdata <= bus.rdata;
        end
    end

endmodule

// File: design/sdram_cmd_arbiter.sv
/* merges the four bank command slots onto the sdram pins
   rotating priority, one grant per cycle, read data routed back by bank */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_cmd_arbiter import sdram_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SDRAM_DW-1:0]    dq_in,
    sdram_bank_if.arb               bank [4],
    output sdram_cmd_e              sdram_cmd,
    output logic [1:0]              sdram_ba,
    output logic [`SDRAM_ROW_W-1:0] sdram_a,
    output logic [`SDRAM_DW-1:0]    dq_out,
    output logic                    dq_oe
);

    localparam int CL = `SDRAM_CL;

    logic [3:0]              req_v;
    sdram_cmd_e              cmd_a   [4];
    logic [`SDRAM_ROW_W-1:0] row_a   [4];
    logic [`SDRAM_COL_W-1:0] col_a   [4];
    logic [`SDRAM_DW-1:0]    wdata_a [4];
    logic [3:0]              grant_q;
    logic [1:0]              ptr;
    logic [1:0]              sel;
    logic                    found;
    logic [`SDRAM_ROW_W-1:0] col_addr;
    // read return pipe, one entry per cycle of CAS latency
    logic [CL-1:0]           rd_v;
    logic [CL-1:0][1:0]      rd_ba;

    for (genvar i = 0; i < 4; i++) begin : g_bank
        // a bank still holds req during its grant cycle, skip it there
        assign req_v[i]       = bank[i].req & ~grant_q[i];
        assign cmd_a[i]       = bank[i].cmd;
        assign row_a[i]       = bank[i].row;
        assign col_a[i]       = bank[i].col;
        assign wdata_a[i]     = bank[i].wdata;
        assign bank[i].grant  = grant_q[i];
        assign bank[i].rvalid = rd_v[CL-1] && (rd_ba[CL-1] == 2'(i));
        assign bank[i].rdata  = dq_in;
    end

    // first requester at or after the pointer
    always_comb begin : pick
        logic [1:0] idx;
        found = 1'b0;
        sel   = ptr;
        for (int k = 0; k < 4; k++) begin
            idx = ptr + 2'(k);
            if (!found && req_v[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    // column address with a[10] set for auto-precharge
    always_comb begin
        col_addr                     = '0;
        col_addr[`SDRAM_COL_W-1:0]   = col_a[sel];
        col_addr[10]                 = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_cmd <= CMD_NOP;
            dq_oe     <= 1'b0;
            grant_q   <= '0;
            ptr       <= '0;
            rd_v      <= '0;
        end else begin
            sdram_cmd <= found ? cmd_a[sel] : CMD_NOP;
            dq_oe     <= found && (cmd_a[sel] == CMD_WRITE);
            grant_q   <= found ? (4'b0001 << sel) : 4'b0000;
            if (found) begin
                ptr <= sel + 2'd1;
            end
            // a READ on the pins now returns CL cycles later
            rd_v[0] <= (sdram_cmd == CMD_READ);
            for (int k = 1; k < CL; k++) begin
                rd_v[k] <= rd_v[k-1];
            end
        end
    end

    // pin payload and bank tags
    always_ff @(posedge clk) begin
        sdram_ba <= sel;
        sdram_a  <= (cmd_a[sel] == CMD_ACT) ? row_a[sel] : col_addr;
        dq_out   <= wdata_a[sel];
        rd_ba[0] <= sdram_ba;
        for (int k = 1; k < CL; k++) begin
            rd_ba[k] <= rd_ba[k-1];
        end
    end

endmodule

// File: design/sdram_frontend.sv
/* request front end of a four-bank sdram controller
   one client per bank, shared command pins, data returned per bank */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_frontend import sdram_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_addr_t             addr  [4],
    input  logic [`SDRAM_DW-1:0]    wdata [4],
    input  logic [3:0]              rd,
    input  logic [3:0]              wr,
    input  logic [`SDRAM_DW-1:0]    dq_in,
    output logic [`SDRAM_DW-1:0]    rdata [4],
    output logic [3:0]              ack,
    output sdram_cmd_e              sdram_cmd,
    output logic [1:0]              sdram_ba,
    output logic [`SDRAM_ROW_W-1:0] sdram_a,
    output logic [`SDRAM_DW-1:0]    dq_out,
    output logic                    dq_oe
);

    // requests after the optional register stage
    sdram_addr_t          addr_l  [4];
    logic [`SDRAM_DW-1:0] wdata_l [4];
    logic [3:0]           rd_l;
    logic [3:0]           wr_l;

    // one command slot per bank
    sdram_bank_if bank_bus [4] ();

    sdram_req_latch u_latch (
        .clk     (clk),
        .rst     (rst),
        .addr    (addr),
        .wdata   (wdata),
        .rd      (rd),
        .wr      (wr),
        .addr_l  (addr_l),
        .wdata_l (wdata_l),
        .rd_l    (rd_l),
        .wr_l    (wr_l)
    );

    for (genvar i = 0; i < 4; i++) begin : g_seq
        sdram_bank_seq u_seq (
            .clk   (clk),
            .rst   (rst),
            .addr  (addr_l[i]),
            .wdata (wdata_l[i]),
            .rd    (rd_l[i]),
            .wr    (wr_l[i]),
            .rdata (rdata[i]),
            .ack   (ack[i]),
            .bus   (bank_bus[i])
        );
    end

    sdram_cmd_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .dq_in     (dq_in),
        .bank      (bank_bus),
        .sdram_cmd (sdram_cmd),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe)
    );

endmodule

// File: testbench/sdram_model.sv
/* behavioral sdram on the controller pins for simulation
   stores words by bank, open row and column, returns reads after CAS latency */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_model import sdram_pkg::*; (
    input  logic                    clk,
    input  sdram_cmd_e              cmd,
    input  logic [1:0]              ba,
    input  logic [`SDRAM_ROW_W-1:0] a,
    input  logic [`SDRAM_DW-1:0]    dq_out,
    input  logic                    dq_oe,
    output logic [`SDRAM_DW-1:0]    dq_in
);

    localparam int CL    = `SDRAM_CL;
    localparam int KEY_W = 2 + `SDRAM_ROW_W + `SDRAM_COL_W;

    // sparse storage keyed by {bank, row, col}
    logic [`SDRAM_DW-1:0]    mem      [logic [KEY_W-1:0]];
    logic [`SDRAM_ROW_W-1:0] open_row [4];
    // banks with a row still open
    logic [3:0]              bank_open;
    // read data on its way to the pins over CL-1 stages
    logic [`SDRAM_DW-1:0]    pipe     [CL-1];

    // never-written words still depend on every address bit
    function automatic logic [`SDRAM_DW-1:0] fill_word(input logic [KEY_W-1:0] key);
        return `SDRAM_DW'(key) ^ `SDRAM_DW'(key >> `SDRAM_DW) ^ 16'hc3a5;
    endfunction

    initial begin
        dq_in     = '0;
        bank_open = '0;
        for (int i = 0; i < CL - 1; i++) begin
            pipe[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            open_row[i] = '0;
        end
    end

    always @(posedge clk) begin : decode
        logic [KEY_W-1:0] key;
        key = {ba, open_row[ba], a[`SDRAM_COL_W-1:0]};
        // an unprecharged bank keeps its old row on ACT
        if (cmd == CMD_ACT && !bank_open[ba]) begin
            open_row[ba]  <= a;
            bank_open[ba] <= 1'b1;
        end
        // only a[10] on the column command closes the bank
        if ((cmd == CMD_READ || cmd == CMD_WRITE) && a[10]) begin
            bank_open[ba] <= 1'b0;
        end
        // write data sits on dq in the same cycle as the command
        if (cmd == CMD_WRITE && dq_oe) begin
            mem[key] = dq_out;
        end
        if (cmd == CMD_READ) begin
            pipe[0] <= mem.exists(key) ? mem[key] : fill_word(key);
        end
        for (int k = 1; k < CL - 1; k++) begin
            pipe[k] <= pipe[k-1];
        end
        // lands CL cycles after the READ cycle
        dq_in <= pipe[CL-2];
    end

endmodule

// File: testbench/sdram_assertions.sv
/* protocol checks on the sdram command pins, bound into the front end
   column commands need an open row and tRCD, dq only driven for writes */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_assertions import sdram_pkg::*; (
    input logic       clk,
    input logic       rst,
    input sdram_cmd_e sdram_cmd,
    input logic [1:0] sdram_ba,
    input logic       dq_oe
);

    // read back by the testbench
    int unsigned fail_cnt = 0;

    logic [3:0] row_open;
    // cycles since the last ACT per bank, saturating
    logic [2:0] act_age [4];
    logic       col_cmd;

    assign col_cmd = (sdram_cmd == CMD_READ) || (sdram_cmd == CMD_WRITE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_open <= '0;
            for (int i = 0; i < 4; i++) begin
                act_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (act_age[i] != '1) begin
                    act_age[i] <= act_age[i] + 1'b1;
                end
            end
            if (sdram_cmd == CMD_ACT) begin
                row_open[sdram_ba] <= 1'b1;
                act_age[sdram_ba]  <= 3'd1;
            end
            // auto-precharge closes the row
            if (col_cmd) begin
                row_open[sdram_ba] <= 1'b0;
            end
        end
    end

    a_row_open: assert property (@(posedge clk) disable iff (rst)
        col_cmd |-> row_open[sdram_ba])
        else begin
            $error("column command on bank %0d with no open row", sdram_ba);
            fail_cnt++;
        end

    a_trcd: assert property (@(posedge clk) disable iff (rst)
        col_cmd |-> (act_age[sdram_ba] >= 3'(`SDRAM_TRCD)))
        else begin
            $error("column command on bank %0d too soon after ACT", sdram_ba);
            fail_cnt++;
        end

    a_dq_oe: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> (sdram_cmd == CMD_WRITE))
        else begin
            $error("dq driven outside a WRITE cycle");
            fail_cnt++;
        end

endmodule

// File: testbench/tb_sdram_frontend.sv
/* directed testbench for the four-bank sdram front end
   clients per bank, a behavioral sdram on the pins, shadow memory for reads */
`timescale 1ns/1ps
`include "sdram_config.svh"

module tb_sdram_frontend import sdram_pkg::*; ();

    localparam int ACK_TIMEOUT = 200;
    localparam int NUM_OPS     = 200;

    logic                    clk;
    logic                    rst;
    sdram_addr_t             addr  [4];
    logic [`SDRAM_DW-1:0]    wdata [4];
    logic [3:0]              rd;
    logic [3:0]              wr;
    logic [`SDRAM_DW-1:0]    dq_in;
    logic [`SDRAM_DW-1:0]    rdata [4];
    logic [3:0]              ack;
    sdram_cmd_e              sdram_cmd;
    logic [1:0]              sdram_ba;
    logic [`SDRAM_ROW_W-1:0] sdram_a;
    logic [`SDRAM_DW-1:0]    dq_out;
    logic                    dq_oe;

    // expected memory contents keyed by {bank, row, col}
    logic [`SDRAM_DW-1:0] shadow [logic [23:0]];

    // random traffic generated up front
    int unsigned          op_bank [NUM_OPS];
    sdram_addr_t          op_addr [NUM_OPS];
    logic [`SDRAM_DW-1:0] op_data [NUM_OPS];
    bit                   op_rd   [NUM_OPS];

    sdram_frontend u_dut (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .wdata     (wdata),
        .rd        (rd),
        .wr        (wr),
        .dq_in     (dq_in),
        .rdata     (rdata),
        .ack       (ack),
        .sdram_cmd (sdram_cmd),
        .sdram_ba  (sdram_ba),
        .sdram_a   (sdram_a),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe)
    );

    sdram_model u_mem (
        .clk    (clk),
        .cmd    (sdram_cmd),
        .ba     (sdram_ba),
        .a      (sdram_a),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    bind sdram_frontend sdram_assertions u_assert (
        .clk       (clk),
        .rst       (rst),
        .sdram_cmd (sdram_cmd),
        .sdram_ba  (sdram_ba),
        .dq_oe     (dq_oe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("error: test %s, %s: expected 0x%0h, actual 0x%0h",
                                     test, what, expected, actual));
        end
    endtask

    // bound protocol checks on the command bus
    always @(posedge clk) begin
        if (u_dut.u_assert.fail_cnt != 0) begin
            report_failure("a command bus protocol assertion failed");
        end
    end

    function automatic logic [23:0] shadow_key(input int b, input sdram_addr_t a);
        return {2'(b), a};
    endfunction

    // one client transaction raises the level, waits for ack and drops it a cycle later
    task automatic bank_access(input string test, input int b, input bit is_wr,
                               input sdram_addr_t a, input logic [`SDRAM_DW-1:0] data,
                               input bit solo, output logic [`SDRAM_DW-1:0] word);
        int waited;
        bit got;
        waited = 0;
        got    = 1'b0;
        @(posedge clk);
        #1;
        addr[b]  = a;
        wdata[b] = data;
        rd[b]    = !is_wr;
        wr[b]    = is_wr;
        while (!got && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
            // no other client is active, so no other ack
            if (solo) begin
                check_value(test, "ack of other banks", 32'h0, 32'(ack & ~(4'b0001 << b)));
            end
            got = ack[b];
        end
        if (!got) begin
            report_failure($sformatf("timeout: bank %0d saw no ack within %0d cycles in test %s",
                                     b, ACK_TIMEOUT, test));
        end
        // read word is valid in the ack cycle
        word = rdata[b];
        @(posedge clk);
        #1;
        rd[b] = 1'b0;
        wr[b] = 1'b0;
    endtask

    task automatic write_word(input string test, input int b, input sdram_addr_t a,
                              input logic [`SDRAM_DW-1:0] data, input bit solo);
        logic [`SDRAM_DW-1:0] unused_word;
        bank_access(test, b, 1'b1, a, data, solo, unused_word);
        shadow[shadow_key(b, a)] = data;
    endtask

    task automatic read_check(input string test, input int b, input sdram_addr_t a,
                              input bit solo);
        logic [`SDRAM_DW-1:0] word;
        logic [23:0]          key;
        key = shadow_key(b, a);
        if (!shadow.exists(key)) begin
            report_failure($sformatf("test %s reads bank %0d at an address never written",
                                     test, b));
        end
        bank_access(test, b, 1'b0, a, '0, solo, word);
        check_value(test, $sformatf("read bank %0d row %0d col %0d", b, a.row, a.col),
                    32'(shadow[key]), 32'(word));
    endtask

    task automatic expect_idle_pins(input string test);
        check_value(test, "ack", 32'h0, 32'(ack));
        check_value(test, "sdram_cmd", 32'(CMD_NOP), 32'(sdram_cmd));
        check_value(test, "dq_oe", 32'h0, 32'(dq_oe));
    endtask

    task automatic reset_state();
        repeat (2) begin
            @(posedge clk);
            #1;
            expect_idle_pins("reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        expect_idle_pins("reset");
    endtask

    task automatic single_bank_rw();
        sdram_addr_t a;
        a.row = 13'd1234;
        a.col = 9'd17;
        write_word("single", 0, a, 16'hbeef, 1'b1);
        read_check("single", 0, a, 1'b1);
    endtask

    // all four clients at once on the same row and column with distinct data
    task automatic concurrent_banks();
        sdram_addr_t a;
        a.row = 13'd77;
        a.col = 9'd300;
        for (int b = 0; b < 4; b++) begin
            fork
                automatic int bank_n = b;
                write_word("concurrent", bank_n, a, 16'(16'h3c00 + 16'h0111 * bank_n), 1'b0);
            join_none
        end
        wait fork;
        for (int b = 0; b < 4; b++) begin
            fork
                automatic int bank_n = b;
                read_check("concurrent", bank_n, a, 1'b0);
            join_none
        end
        wait fork;
    endtask

    // each access closes its row, so every one reopens a row
    task automatic row_change();
        sdram_addr_t a0;
        sdram_addr_t a1;
        sdram_addr_t a2;
        a0 = '{row: 13'd5, col: 9'd3};
        a1 = '{row: 13'd900, col: 9'd3};
        a2 = '{row: 13'd5, col: 9'd4};
        write_word("row_change", 2, a0, 16'h1111, 1'b1);
        write_word("row_change", 2, a1, 16'h2222, 1'b1);
        write_word("row_change", 2, a2, 16'h3333, 1'b1);
        read_check("row_change", 2, a1, 1'b1);
        read_check("row_change", 2, a0, 1'b1);
        read_check("row_change", 2, a2, 1'b1);
        read_check("row_change", 2, a1, 1'b1);
    endtask

    // ops of one bank in order where a read of an unwritten word turns into a write
    task automatic run_bank_ops(input int b);
        for (int n = 0; n < NUM_OPS; n++) begin
            if (op_bank[n] == b) begin
                if (op_rd[n] && shadow.exists(shadow_key(b, op_addr[n]))) begin
                    read_check("random", b, op_addr[n], 1'b0);
                end else begin
                    write_word("random", b, op_addr[n], op_data[n], 1'b0);
                end
            end
        end
    endtask

    task automatic random_traffic();
        // small address pool so reads hit earlier writes
        for (int n = 0; n < NUM_OPS; n++) begin
            op_bank[n]     = $urandom_range(0, 3);
            op_addr[n].row = 13'($urandom_range(0, 7) * 1021);
            op_addr[n].col = 9'($urandom_range(0, 7) * 61);
            op_data[n]     = 16'($urandom);
            op_rd[n]       = 1'($urandom_range(0, 1));
        end
        for (int b = 0; b < 4; b++) begin
            fork
                automatic int bank_n = b;
                run_bank_ops(bank_n);
            join_none
        end
        wait fork;
    endtask

    initial begin
        rst = 1'b1;
        rd  = '0;
        wr  = '0;
        for (int i = 0; i < 4; i++) begin
            addr[i]  = '0;
            wdata[i] = '0;
        end
        void'($urandom(29));
        reset_state();
        single_bank_rw();
        concurrent_banks();
        row_change();
        random_traffic();
        if (u_dut.u_assert.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure("command bus protocol assertions failed during the run");
        end
    end

endmodule

// File: files.f
+incdir+design
design/sdram_pkg.sv
design/sdram_bank_if.sv
design/sdram_req_latch.sv
design/sdram_bank_seq.sv
design/sdram_cmd_arbiter.sv
design/sdram_frontend.sv
testbench/sdram_model.sv
testbench/sdram_assertions.sv
testbench/tb_sdram_frontend.sv
